/* source/tpl_adc_config.svh */
/*
 * Fixed link and converter configuration of the ADC transport layer.
 * Include this wherever a size is needed. The package builds its types from it.
 */

`ifndef TPL_ADC_CONFIG_SVH
`define TPL_ADC_CONFIG_SVH

// Link layer geometry
`define TPL_NUM_LANES        2
`define TPL_OCTETS_PER_BEAT  4

// Converter side, one sample per frame
`define TPL_NUM_CHANNELS     2
`define TPL_CONV_RES         14
`define TPL_BITS_PER_SAMPLE  16
// Samples of one channel carried in each link beat
`define TPL_SAMPLES_PER_CH   2

// PN generator lengths and feedback taps, x^LEN + x^TAP + 1
`define TPL_PN9_LEN          9
`define TPL_PN9_TAP          5
`define TPL_PN23_LEN         23
`define TPL_PN23_TAP         18

// Consecutive beats needed to gain and to lose pattern sync
`define TPL_PN_LOCK_BEATS    16
`define TPL_PN_LOSS_BEATS    8
`define TPL_CNT_W            5

`endif

/* source/tpl_adc_pkg.sv */
/*
 * Beat, sample, control and status types of the ADC transport layer.
 * Modules refer to these by scoped name in ports and import them in the body.
 */

`default_nettype none

`include "tpl_adc_config.svh"

package tpl_adc_pkg;

  // One link beat, seen as lane octets or as 16-bit sample containers
  // The word view only holds samples once the octet order has been fixed up
  typedef union packed {
    logic [`TPL_NUM_LANES-1:0][`TPL_OCTETS_PER_BEAT-1:0][7:0] octets;
    logic [`TPL_NUM_LANES*`TPL_OCTETS_PER_BEAT*8/`TPL_BITS_PER_SAMPLE-1:0]
          [`TPL_BITS_PER_SAMPLE-1:0] words;
  } link_beat_u;

  // Converter code without the tail bits
  typedef logic [`TPL_CONV_RES-1:0] raw_sample_t;

  // Samples of one channel in one beat, sample 0 is the older one
  typedef struct packed {
    raw_sample_t [`TPL_SAMPLES_PER_CH-1:0] samples;
  } ch_raw_t;

  // Formatted DMA words of one channel in one beat
  typedef struct packed {
    logic [`TPL_SAMPLES_PER_CH-1:0][`TPL_BITS_PER_SAMPLE-1:0] words;
  } ch_fmt_t;

  // Data format control, dtype set means the input is offset binary
  typedef struct packed {
    logic enable;
    logic sign_extend;
    logic dtype;
  } dfmt_ctrl_t;

  // Test pattern select, unlisted codes behave as off
  typedef enum logic [3:0] {
    PN_OFF = 4'd0,
    PN_9   = 4'd1,
    PN_23  = 4'd2
  } pn_sel_t;

  typedef struct packed {
    logic err;
    logic oos;
  } pn_status_t;

endpackage

`default_nettype wire

/* source/tpl_adc_deframer.sv */
/*
 * Deframes each link beat into per-channel converter samples.
 * Output samples and their valid strobe are registered one cycle after the beat.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_deframer (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      link_valid,
  input  wire tpl_adc_pkg::link_beat_u   link_data,
  output logic                           raw_valid,
  output tpl_adc_pkg::ch_raw_t [`TPL_NUM_CHANNELS-1:0] raw
);

  import tpl_adc_pkg::*;

  // Beat with the two octets of every container swapped into word order
  link_beat_u                          swapped;
  ch_raw_t [`TPL_NUM_CHANNELS-1:0]     raw_next;

  // **************************************************
  // Octet reorder
  // **************************************************

  // JESD204 sends the most significant octet first, so the lower octet
  // address of each pair is the high byte of the container
  always_comb begin
    for (int l = 0; l < `TPL_NUM_LANES; l++) begin
      for (int m = 0; m < `TPL_OCTETS_PER_BEAT / 2; m++) begin
        swapped.octets[l][2*m]   = link_data.octets[l][2*m+1];
        swapped.octets[l][2*m+1] = link_data.octets[l][2*m];
      end
    end
  end

  // Consecutive containers belong to the same channel
  // The converter code sits in the top bits and the tail bits are dropped
  always_comb begin
    for (int c = 0; c < `TPL_NUM_CHANNELS; c++) begin
      for (int s = 0; s < `TPL_SAMPLES_PER_CH; s++) begin
        raw_next[c].samples[s] =
          swapped.words[c*`TPL_SAMPLES_PER_CH+s][`TPL_BITS_PER_SAMPLE-1 -: `TPL_CONV_RES];
      end
    end
  end

  // **************************************************
  // Output register
  // **************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      raw_valid <= 1'b0;
    end else begin
      raw_valid <= link_valid;
    end
  end

  // Samples hold their last value across idle beats
  always_ff @(posedge clk) begin
    if (link_valid) begin
      raw <= raw_next;
    end
  end

endmodule

`default_nettype wire

/* source/tpl_adc_data_format.sv */
/*
 * Formats one channel's raw converter codes into 16-bit DMA words.
 * Handles offset binary conversion and sign extension, one register stage.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_data_format (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    raw_valid,
  input  wire tpl_adc_pkg::ch_raw_t    raw,
  input  wire tpl_adc_pkg::dfmt_ctrl_t ctrl,
  output logic                         fmt_valid,
  output tpl_adc_pkg::ch_fmt_t         fmt
);

  import tpl_adc_pkg::*;

  ch_fmt_t fmt_next;

  // Formats a single code according to the control word
  function automatic logic [`TPL_BITS_PER_SAMPLE-1:0] format_code(raw_sample_t code,
                                                                  dfmt_ctrl_t  c);
    raw_sample_t conv;
    logic        ext;
    conv = code;
    ext  = 1'b0;
    if (c.enable) begin
      // Flipping the MSB turns offset binary into two's complement
      conv[`TPL_CONV_RES-1] = code[`TPL_CONV_RES-1] ^ c.dtype;
      ext = c.sign_extend & conv[`TPL_CONV_RES-1];
    end
    // Without enable the code is simply zero-extended
    return {{(`TPL_BITS_PER_SAMPLE-`TPL_CONV_RES){ext}}, conv};
  endfunction

  always_comb begin
    for (int s = 0; s < `TPL_SAMPLES_PER_CH; s++) begin
      fmt_next.words[s] = format_code(raw.samples[s], ctrl);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fmt_valid <= 1'b0;
    end else begin
      fmt_valid <= raw_valid;
    end
  end

  // Words only move on a valid beat
  always_ff @(posedge clk) begin
    if (raw_valid) begin
      fmt <= fmt_next;
    end
  end

endmodule

`default_nettype wire

/* source/tpl_adc_pn_check.sv */
/*
 * Self-synchronizing PN9 and PN23 checker for one channel.
 * Predicts each code from the codes before it and flags one match per valid beat.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_pn_check (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  raw_valid,
  input  wire tpl_adc_pkg::ch_raw_t  raw,
  input  wire tpl_adc_pkg::pn_sel_t  sel,
  output logic                       beat_valid,
  output logic                       beat_match
);

  import tpl_adc_pkg::*;

  localparam int res    = `TPL_CONV_RES;
  localparam int spc    = `TPL_SAMPLES_PER_CH;
  localparam int hist_w = `TPL_PN23_LEN;

  // Last two codes of the previous valid beat, hist_new is the most recent
  raw_sample_t                    hist_old;
  raw_sample_t                    hist_new;
  // History followed by this beat's samples, oldest first
  raw_sample_t [spc+1:0]          chain;
  raw_sample_t [spc-1:0]          expected;
  logic [spc-1:0]                 sample_ok;
  logic                           use_pn23;

  assign use_pn23 = (sel == PN_23);

  // **************************************************
  // Expected code
  // **************************************************

  // The seed holds previous output bits with the newest bit in the LSB
  // Bit k-1 of the state is the output from k steps back, so x^k maps to it
  // PN9 only looks at the low 9 bits of the same seed
  function automatic raw_sample_t pn_expect(logic [2*res-1:0] seed, logic pn23);
    logic [hist_w-1:0] s;
    logic              fb;
    raw_sample_t       code;
    s    = seed[hist_w-1:0];
    code = '0;
    for (int i = 0; i < res; i++) begin
      if (pn23) begin
        fb = s[`TPL_PN23_LEN-1] ^ s[`TPL_PN23_TAP-1];
      end else begin
        fb = s[`TPL_PN9_LEN-1] ^ s[`TPL_PN9_TAP-1];
      end
      // First generated bit ends up as the MSB of the code
      code = {code[res-2:0], fb};
      s    = {s[hist_w-2:0], fb};
    end
    return code;
  endfunction

  always_comb begin
    chain[0] = hist_old;
    chain[1] = hist_new;
    for (int s = 0; s < spc; s++) begin
      chain[s+2] = raw.samples[s];
    end
    // Each sample is predicted from the two codes in front of it
    for (int s = 0; s < spc; s++) begin
      expected[s]  = pn_expect({chain[s], chain[s+1]}, use_pn23);
      sample_ok[s] = (expected[s] == chain[s+2]);
    end
  end

  // **************************************************
  // Beat result and history
  // **************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_valid <= 1'b0;
      beat_match <= 1'b0;
      hist_old   <= '0;
      hist_new   <= '0;
    end else begin
      beat_valid <= raw_valid;
      if (raw_valid) begin
        beat_match <= &sample_ok;
        // The last two samples seed the check of the next beat
        hist_old   <= chain[spc];
        hist_new   <= chain[spc+1];
      end
    end
  end

endmodule

`default_nettype wire

/* source/tpl_adc_match_counter.sv */
/*
 * Saturating counter of consecutive pattern events.
 * The sync FSM decides what steps and what clears it.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_match_counter (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  clear,
  input  wire logic                  step,
  output logic [`TPL_CNT_W-1:0]      count
);

  logic at_max;

  // Holds at all ones instead of wrapping back to zero
  assign at_max = &count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      // Clear wins over a step in the same cycle
      count <= '0;
    end else if (step && !at_max) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/tpl_adc_pn_sync_fsm.sv */
/*
 * Two-state pattern sync machine of one channel.
 * Steers the match counter and drives the out-of-sync and error status.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_pn_sync_fsm (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire tpl_adc_pkg::pn_sel_t   sel,
  input  wire logic                   beat_valid,
  input  wire logic                   beat_match,
  input  wire logic [`TPL_CNT_W-1:0]  count,
  output logic                        clear,
  output logic                        step,
  output tpl_adc_pkg::pn_status_t     status
);

  import tpl_adc_pkg::*;

  // Counter values one event short of the thresholds
  localparam logic [`TPL_CNT_W-1:0] lock_last = `TPL_CNT_W'(`TPL_PN_LOCK_BEATS - 1);
  localparam logic [`TPL_CNT_W-1:0] loss_last = `TPL_CNT_W'(`TPL_PN_LOSS_BEATS - 1);

  pn_sel_t sel_q;
  logic    in_sync;
  logic    in_sync_next;
  logic    err_q;
  logic    err_next;
  logic    sel_on;

  assign sel_on = (sel == PN_9) || (sel == PN_23);

  // **************************************************
  // Next state
  // **************************************************

  always_comb begin
    clear        = 1'b0;
    step         = 1'b0;
    err_next     = 1'b0;
    in_sync_next = in_sync;
    if (!sel_on || (sel != sel_q)) begin
      // A new or disabled pattern always starts over out of sync
      clear        = 1'b1;
      in_sync_next = 1'b0;
    end else if (beat_valid) begin
      if (!in_sync) begin
        // Out of sync a run of good beats is needed to lock
        if (!beat_match) begin
          clear = 1'b1;
        end else if (count == lock_last) begin
          clear        = 1'b1;
          in_sync_next = 1'b1;
        end else begin
          step = 1'b1;
        end
      end else if (beat_match) begin
        clear = 1'b1;
      end else begin
        // Every bad beat in sync is reported, even the one that drops sync
        err_next = 1'b1;
        if (count == loss_last) begin
          clear        = 1'b1;
          in_sync_next = 1'b0;
        end else begin
          step = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q   <= PN_OFF;
      in_sync <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      sel_q   <= sel;
      in_sync <= in_sync_next;
      err_q   <= err_next;
    end
  end

  assign status.err = err_q;
  assign status.oos = ~in_sync;

endmodule

`default_nettype wire

/* source/tpl_adc_channel.sv */
/*
 * One converter channel of the transport layer.
 * Formats the samples for DMA and monitors them against the selected PN pattern.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_channel (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    raw_valid,
  input  wire tpl_adc_pkg::ch_raw_t    raw,
  input  wire tpl_adc_pkg::dfmt_ctrl_t ctrl,
  input  wire tpl_adc_pkg::pn_sel_t    sel,
  output logic                         fmt_valid,
  output tpl_adc_pkg::ch_fmt_t         fmt,
  output tpl_adc_pkg::pn_status_t      status
);

  logic                   beat_valid;
  logic                   beat_match;
  logic                   cnt_clear;
  logic                   cnt_step;
  logic [`TPL_CNT_W-1:0]  count;

  // DMA path
  tpl_adc_data_format i_data_format (
    .clk       (clk),
    .rst       (rst),
    .raw_valid (raw_valid),
    .raw       (raw),
    .ctrl      (ctrl),
    .fmt_valid (fmt_valid),
    .fmt       (fmt)
  );

  // Pattern monitor works on the unformatted codes
  tpl_adc_pn_check i_pn_check (
    .clk        (clk),
    .rst        (rst),
    .raw_valid  (raw_valid),
    .raw        (raw),
    .sel        (sel),
    .beat_valid (beat_valid),
    .beat_match (beat_match)
  );

  tpl_adc_match_counter i_match_counter (
    .clk   (clk),
    .rst   (rst),
    .clear (cnt_clear),
    .step  (cnt_step),
    .count (count)
  );

  tpl_adc_pn_sync_fsm i_pn_sync_fsm (
    .clk        (clk),
    .rst        (rst),
    .sel        (sel),
    .beat_valid (beat_valid),
    .beat_match (beat_match),
    .count      (count),
    .clear      (cnt_clear),
    .step       (cnt_step),
    .status     (status)
  );

endmodule

`default_nettype wire

/* source/tpl_adc_core.sv */
/*
 * Top level of the JESD204 receive transport layer.
 * Deframes link beats and hands each channel's samples to its own channel block.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_core (
  input  wire logic                                              clk,
  input  wire logic                                              rst,
  // Link layer side, the link is always ready
  input  wire logic                                              link_valid,
  input  wire tpl_adc_pkg::link_beat_u                           link_data,
  // Per-channel controls
  input  wire tpl_adc_pkg::dfmt_ctrl_t [`TPL_NUM_CHANNELS-1:0]   dfmt_ctrl,
  input  wire tpl_adc_pkg::pn_sel_t [`TPL_NUM_CHANNELS-1:0]      pn_sel,
  // DMA side, channel 0 in the lowest bits
  output logic                                                   adc_valid,
  output tpl_adc_pkg::ch_fmt_t [`TPL_NUM_CHANNELS-1:0]           adc_data,
  output tpl_adc_pkg::pn_status_t [`TPL_NUM_CHANNELS-1:0]        pn_status
);

  import tpl_adc_pkg::*;

  logic                             raw_valid;
  ch_raw_t [`TPL_NUM_CHANNELS-1:0]  raw;
  logic [`TPL_NUM_CHANNELS-1:0]     fmt_valid;

  tpl_adc_deframer i_deframer (
    .clk        (clk),
    .rst        (rst),
    .link_valid (link_valid),
    .link_data  (link_data),
    .raw_valid  (raw_valid),
    .raw        (raw)
  );

  // **************************************************
  // Channel array
  // **************************************************

  for (genvar i = 0; i < `TPL_NUM_CHANNELS; i++) begin : g_channel
    tpl_adc_channel i_channel (
      .clk       (clk),
      .rst       (rst),
      .raw_valid (raw_valid),
      .raw       (raw[i]),
      .ctrl      (dfmt_ctrl[i]),
      .sel       (pn_sel[i]),
      .fmt_valid (fmt_valid[i]),
      .fmt       (adc_data[i]),
      .status    (pn_status[i])
    );
  end

  // All channels run in lockstep so one strobe serves them all
  assign adc_valid = fmt_valid[0];

endmodule

`default_nettype wire

/* tb/tpl_adc_tb.sv */
/*
 * Directed testbench of the ADC transport layer core.
 * Drives link beats, models the deframing, format and PN rules, and checks the DUT outputs.
 */

`default_nettype none

`include "tpl_adc_config.svh"

module tpl_adc_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import tpl_adc_pkg::*;

  localparam int nch             = `TPL_NUM_CHANNELS;
  localparam int beats_per_ctrl  = 12;
  localparam int err_events      = 4;
  // One lock run is the lock count plus the two idle cycles that observe it
  localparam int cycles_lock     = `TPL_PN_LOCK_BEATS + 2;
  localparam int cycles_total    = 10 + 8 * (beats_per_ctrl + 2) + 3 * cycles_lock + 8
                                   + err_events * 10 + `TPL_PN_LOSS_BEATS + 16;
  localparam int watchdog_cycles = 2 * cycles_total + 50;

  logic                      clk;
  logic                      rst;
  logic                      link_valid;
  link_beat_u                link_data;
  dfmt_ctrl_t [nch-1:0]      dfmt_ctrl;
  pn_sel_t [nch-1:0]         pn_sel;
  logic                      adc_valid;
  ch_fmt_t [nch-1:0]         adc_data;
  pn_status_t [nch-1:0]      pn_status;

  logic [31:0] rng = 32'he5bc;
  int          checks;
  int          errors;
  int          base_checks;
  int          base_errors;
  // Reference PN generators, one per channel, newest bit in bit 0
  logic [31:0] gen_hist [nch];
  logic        gen_pn23 [nch];
  // Number of cycles each channel has shown err high
  int          err_seen [nch] = '{default: 0};

  tpl_adc_core dut_i (
    .clk        (clk),
    .rst        (rst),
    .link_valid (link_valid),
    .link_data  (link_data),
    .dfmt_ctrl  (dfmt_ctrl),
    .pn_sel     (pn_sel),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .pn_status  (pn_status)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    for (int c = 0; c < nch; c++) begin
      if (!rst && pn_status[c].err === 1'b1) begin
        err_seen[c]++;
      end
    end
  end

  // **************************************************
  // Helpers and reference models
  // **************************************************

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic start_test();
    base_checks = checks;
    base_errors = errors;
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - base_checks, errors - base_errors);
  endtask

  // Container k carries its high byte in octet 2*(k mod 2) of lane k/2,
  // the low byte follows it, and the code sits above two tail bits
  function automatic link_beat_u build_beat(input raw_sample_t c0, input raw_sample_t c1,
                                            input raw_sample_t c2, input raw_sample_t c3,
                                            input logic [31:0] tails);
    raw_sample_t codes [4];
    logic [15:0] word;
    link_beat_u  beat;
    codes[0] = c0;
    codes[1] = c1;
    codes[2] = c2;
    codes[3] = c3;
    for (int k = 0; k < 4; k++) begin
      word = {codes[k], tails[2*k +: 2]};
      beat.octets[k/2][2*(k%2)]   = word[15:8];
      beat.octets[k/2][2*(k%2)+1] = word[7:0];
    end
    return beat;
  endfunction

  function automatic logic [15:0] format_word(input raw_sample_t code, input dfmt_ctrl_t ctl);
    raw_sample_t c;
    logic [1:0]  top;
    c   = code;
    top = 2'b00;
    if (ctl.enable) begin
      if (ctl.dtype) begin
        c[13] = ~c[13];
      end
      if (ctl.sign_extend) begin
        top = {2{c[13]}};
      end
    end
    return {top, c};
  endfunction

  task automatic seed_generator(input int ch, input logic pn23);
    gen_pn23[ch] = pn23;
    gen_hist[ch] = next_random() | 32'h1;
  endtask

  // Free running Fibonacci LFSR, 14 bits per code, first bit in the MSB
  task automatic next_code(input int ch, output raw_sample_t code);
    int   len;
    int   tap;
    logic b;
    len  = gen_pn23[ch] ? 23 : 9;
    tap  = gen_pn23[ch] ? 18 : 5;
    code = '0;
    repeat (14) begin
      b = gen_hist[ch][len-1] ^ gen_hist[ch][tap-1];
      gen_hist[ch] = {gen_hist[ch][30:0], b};
      code = {code[12:0], b};
    end
  endtask

  task automatic idle_cycles(input int n);
    link_valid = 1'b0;
    repeat (n) step_cycle();
  endtask

  // Flipping the MSB of channel 1's sample 0 breaks only this beat, since the next
  // beat is predicted from the low 23 bits of this beat's two codes
  task automatic stream_beat(input logic bad1);
    raw_sample_t a0;
    raw_sample_t a1;
    raw_sample_t b0;
    raw_sample_t b1;
    next_code(0, a0);
    next_code(0, a1);
    next_code(1, b0);
    next_code(1, b1);
    b0[13] = b0[13] ^ bad1;
    link_data  = build_beat(a0, a1, b0, b1, next_random());
    link_valid = 1'b1;
    step_cycle();
  endtask

  // Expects sync exactly three cycles after the last of the lock beats
  task automatic lock_channel(input int ch);
    for (int b = 0; b < `TPL_PN_LOCK_BEATS; b++) begin
      stream_beat(1'b0);
      check_value(pn_status[ch].oos, 1'b1, $sformatf("ch%0d oos while locking", ch));
    end
    idle_cycles(1);
    check_value(pn_status[ch].oos, 1'b1, $sformatf("ch%0d oos two cycles after lock", ch));
    idle_cycles(1);
    check_value(pn_status[ch].oos, 1'b0, $sformatf("ch%0d oos three cycles after lock", ch));
  endtask

  task automatic check_reset_state();
    check_value(adc_valid, 1'b0, "adc_valid after reset");
    for (int c = 0; c < nch; c++) begin
      check_value(pn_status[c].oos, 1'b1, $sformatf("ch%0d oos after reset", c));
      check_value(pn_status[c].err, 1'b0, $sformatf("ch%0d err after reset", c));
    end
  endtask

  // **************************************************
  // Directed tests
  // **************************************************

  task automatic run_reset_checks();
    start_test();
    // A valid beat during reset must not leak out
    link_valid = 1'b1;
    link_data  = {next_random(), next_random()};
    repeat (2) step_cycle();
    check_reset_state();
    repeat (2) step_cycle();
    rst        = 1'b0;
    link_valid = 1'b0;
    repeat (3) begin
      step_cycle();
      check_reset_state();
    end
    finish_test("reset");
  endtask

  task automatic check_format();
    logic [31:0]  r0;
    logic [31:0]  r1;
    logic [31:0]  r2;
    raw_sample_t  c [4];
    logic         v;
    logic         pipe_v [2];
    logic [63:0]  pipe_d [2];
    start_test();
    pipe_v[0] = 1'b0;
    pipe_v[1] = 1'b0;
    pipe_d[0] = '0;
    pipe_d[1] = '0;
    for (int i = 0; i < 8; i++) begin
      dfmt_ctrl[0] = dfmt_ctrl_t'(3'(i));
      dfmt_ctrl[1] = dfmt_ctrl_t'(3'(7 - i));
      for (int b = 0; b < beats_per_ctrl + 2; b++) begin
        // Outputs now show the beat driven two cycles ago
        check_value(adc_valid, pipe_v[1], "adc_valid");
        if (pipe_v[1]) begin
          check_value(adc_data, pipe_d[1], $sformatf("adc_data, ctrl %0d", i));
        end
        pipe_v[1] = pipe_v[0];
        pipe_d[1] = pipe_d[0];
        r0 = next_random();
        r1 = next_random();
        r2 = next_random();
        c[0] = r0[13:0];
        c[1] = r0[27:14];
        c[2] = r1[13:0];
        c[3] = r1[27:14];
        // Two idle beats at the end of each setting drain the pipeline
        v = (b < beats_per_ctrl) && (r2[31:30] != 2'b00);
        link_valid = v;
        link_data  = build_beat(c[0], c[1], c[2], c[3], r2);
        pipe_v[0]  = v;
        pipe_d[0]  = {format_word(c[3], dfmt_ctrl[1]), format_word(c[2], dfmt_ctrl[1]),
                      format_word(c[1], dfmt_ctrl[0]), format_word(c[0], dfmt_ctrl[0])};
        step_cycle();
      end
    end
    link_valid = 1'b0;
    finish_test("format");
  endtask

  task automatic lock_on_pn9();
    int base0;
    int base1;
    start_test();
    base0 = err_seen[0];
    base1 = err_seen[1];
    seed_generator(0, 1'b0);
    seed_generator(1, 1'b1);
    // First beat only fills the checker history while both patterns are off
    stream_beat(1'b0);
    idle_cycles(3);
    pn_sel[0] = PN_9;
    idle_cycles(2);
    lock_channel(0);
    check_value(pn_status[1].oos, 1'b1, "ch1 oos with pattern off");
    check_value(err_seen[0] - base0, 0, "ch0 err pulses while locking");
    check_value(err_seen[1] - base1, 0, "ch1 err pulses with pattern off");
    finish_test("pn9 lock");
  endtask

  task automatic count_pn23_errors();
    int base0;
    int base1;
    start_test();
    pn_sel[1] = PN_23;
    idle_cycles(2);
    lock_channel(1);
    base0 = err_seen[0];
    for (int e = 0; e < err_events; e++) begin
      base1 = err_seen[1];
      stream_beat(1'b0);
      idle_cycles(next_random() % 3);
      stream_beat(1'b1);
      idle_cycles(next_random() % 4);
      stream_beat(1'b0);
      idle_cycles(4);
      check_value(err_seen[1] - base1, 1, $sformatf("ch1 err pulses for bad beat %0d", e));
      check_value(pn_status[1].oos, 1'b0, "ch1 oos after single bad beat");
      check_value(pn_status[0].oos, 1'b0, "ch0 oos on clean stream");
    end
    check_value(err_seen[0] - base0, 0, "ch0 err pulses on clean stream");
    finish_test("pn23 errors");
  endtask

  task automatic lose_and_reselect();
    int base1;
    start_test();
    base1 = err_seen[1];
    repeat (`TPL_PN_LOSS_BEATS) stream_beat(1'b1);
    idle_cycles(1);
    check_value(pn_status[1].oos, 1'b0, "ch1 oos two cycles after last bad beat");
    idle_cycles(1);
    check_value(pn_status[1].oos, 1'b1, "ch1 oos three cycles after last bad beat");
    idle_cycles(2);
    check_value(err_seen[1] - base1, `TPL_PN_LOSS_BEATS, "ch1 err pulses during loss");
    // Channel 0 is still locked on PN9 and drops sync as soon as sel moves
    check_value(pn_status[0].oos, 1'b0, "ch0 oos before reselect");
    pn_sel[0] = PN_23;
    idle_cycles(1);
    check_value(pn_status[0].oos, 1'b1, "ch0 oos one cycle after reselect");
    pn_sel[0] = PN_OFF;
    seed_generator(0, 1'b1);
    stream_beat(1'b0);
    idle_cycles(2);
    pn_sel[0] = PN_23;
    idle_cycles(2);
    lock_channel(0);
    finish_test("loss and reselect");
  endtask

  // **************************************************
  // Sequence and watchdog
  // **************************************************

  initial begin
    rst        = 1'b1;
    link_valid = 1'b0;
    link_data  = '0;
    dfmt_ctrl  = '0;
    pn_sel[0]  = PN_OFF;
    pn_sel[1]  = PN_OFF;
    checks     = 0;
    errors     = 0;
    run_reset_checks();
    check_format();
    lock_on_pn9();
    count_pn23_errors();
    lose_and_reselect();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * 20);
    $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/tpl_adc_pkg.sv
source/tpl_adc_deframer.sv
source/tpl_adc_data_format.sv
source/tpl_adc_pn_check.sv
source/tpl_adc_match_counter.sv
source/tpl_adc_pn_sync_fsm.sv
source/tpl_adc_channel.sv
source/tpl_adc_core.sv
tb/tpl_adc_tb.sv

/* Bender.yml */
package:
  name: tpl_adc

export_include_dirs:
  - source

sources:
  # RTL in compile order
  - files:
      - source/tpl_adc_pkg.sv
      - source/tpl_adc_deframer.sv
      - source/tpl_adc_data_format.sv
      - source/tpl_adc_pn_check.sv
      - source/tpl_adc_match_counter.sv
      - source/tpl_adc_pn_sync_fsm.sv
      - source/tpl_adc_channel.sv
      - source/tpl_adc_core.sv
  # Testbench
  - target: test
    files:
      - tb/tpl_adc_tb.sv
